//--- verilog/phy_test_cfg_pkg.sv
// PHY self-test configuration
// Sizes, one-hot pattern codes and the LFSR used for random fill

package phy_test_cfg_pkg;

   // ====================
   // Sizes
   localparam int num_patterns   = 5;
   localparam int seq_no_width   = 32;
   localparam int pkt_size_width = 11;
   localparam int min_pkt_size   = 8;
   localparam int port_width     = 3;
   localparam int count_width    = 16;

   // One bit per test pattern
   typedef logic [num_patterns-1:0] pattern_t;

   // ====================
   // Pattern codes, lowest bit is sent first
   localparam pattern_t pat_all_0  = 5'b00001;
   localparam pattern_t pat_all_1  = 5'b00010;
   localparam pattern_t pat_alt_01 = 5'b00100;
   localparam pattern_t pat_alt_10 = 5'b01000;
   localparam pattern_t pat_random = 5'b10000;

   // Galois LFSR feedback taps
   localparam logic [seq_no_width-1:0] lfsr_taps = 32'h80200003;

   // Fill words for the alternating patterns
   localparam logic [31:0] word_alt_01 = 32'h55555555;
   localparam logic [31:0] word_alt_10 = 32'haaaaaaaa;

endpackage

//--- verilog/phy_test_word_pkg.sv
// PHY self-test word formats
// FIFO words, packet header and checker verdict

package phy_test_word_pkg;

   // One byte lane of a FIFO word, ctrl bit above its data byte
   typedef struct packed {
      logic       ctrl;
      logic [7:0] data;
   } fifo_lane_t;

   // Four lanes, lane 3 carries the first byte
   typedef struct packed {
      fifo_lane_t [3:0] lane;
   } fifo_word_t;

   // Word 0 of every test packet
   typedef struct packed {
      logic [phy_test_cfg_pkg::port_width-1:0]     port;
      phy_test_cfg_pkg::pattern_t                  pattern;
      logic [12:0]                                 rsvd;
      logic [phy_test_cfg_pkg::pkt_size_width-1:0] pkt_size;
   } pkt_hdr_t;

   // Checker verdict, valid for one cycle per packet
   typedef struct packed {
      logic                       valid;
      logic                       good;
      phy_test_cfg_pkg::pattern_t pattern;
   } chk_result_t;

   // ====================
   // Interleave helpers
   function automatic fifo_word_t pack_word(input logic [31:0] data, input logic [3:0] ctrl);
      fifo_word_t w;
      for (int i = 0; i < 4; i++) begin
         w.lane[i].ctrl = ctrl[i];
         w.lane[i].data = data[8*i +: 8];
      end
      return w;
   endfunction

   function automatic logic [31:0] word_data(input fifo_word_t w);
      logic [31:0] d;
      for (int i = 0; i < 4; i++) begin
         d[8*i +: 8] = w.lane[i].data;
      end
      return d;
   endfunction

   function automatic logic [3:0] word_ctrl(input fifo_word_t w);
      logic [3:0] c;
      for (int i = 0; i < 4; i++) begin
         c[i] = w.lane[i].ctrl;
      end
      return c;
   endfunction

endpackage

//--- verilog/phy_test_pktgen.sv
// PHY self-test packet generator
// Each read strobe presents the next word of a test packet one cycle later.
// Header, sequence number, then pattern fill; wraps to word 0 after the last.

`timescale 1ns/1ps

module phy_test_pktgen (
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic                                        rd_en,
   input  logic [phy_test_cfg_pkg::port_width-1:0]     port,
   input  phy_test_cfg_pkg::pattern_t                  pattern,
   input  logic [phy_test_cfg_pkg::pkt_size_width-1:0] pkt_size,
   input  logic [phy_test_cfg_pkg::seq_no_width-1:0]   seq_no,
   output logic [31:0]                                 data,
   output logic [3:0]                                  ctrl,
   output logic                                        done
);

   localparam int idx_width = phy_test_cfg_pkg::pkt_size_width - 1;

   // Word position within the packet
   logic [idx_width-1:0] word_idx;
   logic [idx_width-1:0] num_words;
   logic [phy_test_cfg_pkg::pkt_size_width:0] size_round;
   logic last;

   // Random fill state
   logic [phy_test_cfg_pkg::seq_no_width-1:0] lfsr;
   logic [phy_test_cfg_pkg::seq_no_width-1:0] lfsr_step;

   logic [31:0] fill;
   logic [3:0] last_ctrl;
   phy_test_word_pkg::pkt_hdr_t hdr;

   // Ceiling of size/4 words
   assign size_round = {1'b0, pkt_size} + 2'd3;
   assign num_words = size_round[phy_test_cfg_pkg::pkt_size_width:2];
   assign last = (word_idx == num_words - 1'b1);

   // Galois step, shift right and fold in taps on a one out
   assign lfsr_step = {1'b0, lfsr[phy_test_cfg_pkg::seq_no_width-1:1]} ^
                      (lfsr[0] ? phy_test_cfg_pkg::lfsr_taps : '0);

   assign hdr.port = port;
   assign hdr.pattern = pattern;
   assign hdr.rsvd = '0;
   assign hdr.pkt_size = pkt_size;

   // Marker lane for the last valid byte, lane 3 is byte 0
   always_comb begin
      case (pkt_size[1:0])
         2'd1:    last_ctrl = 4'b1000;
         2'd2:    last_ctrl = 4'b0100;
         2'd3:    last_ctrl = 4'b0010;
         default: last_ctrl = 4'b0001;
      endcase
   end

   // Fill word per pattern
   always_comb begin
      case (pattern)
         phy_test_cfg_pkg::pat_all_0:  fill = '0;
         phy_test_cfg_pkg::pat_all_1:  fill = '1;
         phy_test_cfg_pkg::pat_alt_01: fill = phy_test_cfg_pkg::word_alt_01;
         phy_test_cfg_pkg::pat_alt_10: fill = phy_test_cfg_pkg::word_alt_10;
         phy_test_cfg_pkg::pat_random: fill = lfsr_step;
         default:                      fill = '0;
      endcase
   end

   // ====================
   // Word counter and done flag
   always_ff @(posedge clk) begin
      if (reset) begin
         word_idx <= '0;
         done <= 1'b0;
      end else if (rd_en) begin
         word_idx <= last ? '0 : word_idx + 1'b1;
         // Done follows the word it belongs to
         done <= last;
      end
   end

   // ====================
   // Output word and LFSR
   always_ff @(posedge clk) begin
      if (rd_en) begin
         if (word_idx == '0) begin
            data <= hdr;
         end else if (word_idx == 1) begin
            data <= seq_no;
            // Seed for the random fill that follows
            lfsr <= seq_no;
         end else begin
            data <= fill;
            lfsr <= lfsr_step;
         end
         ctrl <= last ? last_ctrl : 4'b0000;
      end
   end

endmodule

//--- verilog/phy_test_pktsrc.sv
// PHY self-test packet source
// Sends one packet per enabled pattern in ascending order into the TX FIFO.
// Repeats passes while start stays high, stalls on almost-full.

`timescale 1ns/1ps

module phy_test_pktsrc (
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic                                        start,
   input  phy_test_cfg_pkg::pattern_t                  pat_en,
   input  logic [phy_test_cfg_pkg::pkt_size_width-1:0] pkt_size,
   input  logic [phy_test_cfg_pkg::port_width-1:0]     port,
   input  logic [phy_test_cfg_pkg::seq_no_width-1:0]   seq_no,
   input  logic                                        tx_almost_full,
   output phy_test_word_pkg::fifo_word_t               tx_data,
   output logic                                        tx_wr_en,
   output logic                                        busy,
   output phy_test_cfg_pkg::pattern_t                  curr_pat,
   output logic                                        pkt_done,
   output logic                                        iter_done
);

   typedef enum logic [1:0] {
      st_idle,
      st_find,
      st_xmit
   } state_t;

   state_t state;

   // Pattern selection
   phy_test_cfg_pkg::pattern_t pat_mask;
   phy_test_cfg_pkg::pattern_t pat_above;
   phy_test_cfg_pkg::pattern_t next_pat;
   logic next_wrap;

   // Run parameters
   logic [phy_test_cfg_pkg::pkt_size_width-1:0] size;
   logic [phy_test_cfg_pkg::seq_no_width-1:0] pkt_cnt;

   // Generator side
   logic gen_rd_en;
   logic gen_reset;
   logic gen_valid;
   logic gen_done;
   logic [31:0] gen_data;
   logic [3:0] gen_ctrl;
   logic last_write;

   // ====================
   // Next pattern search
   // Enabled patterns above the current one
   assign pat_above = pat_mask & ~(curr_pat | (curr_pat - 1'b1));
   assign next_wrap = (pat_above == '0);

   // Lowest set bit, from the remaining set or from the start of the mask
   assign next_pat = next_wrap ? (pat_mask & (~pat_mask + 1'b1)) :
                                 (pat_above & (~pat_above + 1'b1));

   // ====================
   // Write path
   // The generator output acts as a one-word holding stage.
   // A word stalled by almost-full stays there, done included.
   assign tx_wr_en = (state == st_xmit) && gen_valid && !tx_almost_full;
   assign last_write = tx_wr_en && gen_done;
   assign tx_data = phy_test_word_pkg::pack_word(gen_data, gen_ctrl);

   // Refill when the stage is empty or drains this cycle.
   // Hold off after the last word so the pattern can advance first.
   assign gen_rd_en = (state == st_xmit) && !(gen_valid && gen_done) &&
                      (!gen_valid || tx_wr_en);

   assign gen_reset = reset || (state == st_idle);
   assign busy = (state != st_idle);

   // ====================
   // Control FSM
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
         pat_mask <= '0;
         curr_pat <= '0;
         pkt_cnt <= '0;
         gen_valid <= 1'b0;
         pkt_done <= 1'b0;
         iter_done <= 1'b0;
      end else begin
         pkt_done <= last_write;
         iter_done <= last_write && next_wrap;

         if (gen_rd_en) begin
            gen_valid <= 1'b1;
         end else if (tx_wr_en) begin
            gen_valid <= 1'b0;
         end

         case (state)
            st_idle: begin
               if (start && pat_en != '0) begin
                  state <= st_find;
                  pat_mask <= pat_en;
                  // Search begins at the lowest pattern
                  curr_pat <= phy_test_cfg_pkg::pat_all_0;
                  pkt_cnt <= '0;
               end
            end
            st_find: begin
               if ((curr_pat & pat_mask) != '0) begin
                  state <= st_xmit;
               end else begin
                  curr_pat <= curr_pat << 1;
               end
            end
            st_xmit: begin
               if (last_write) begin
                  curr_pat <= next_pat;
                  pkt_cnt <= pkt_cnt + 1'b1;
                  // Another pass only while start is held
                  if (next_wrap && !start) begin
                     state <= st_idle;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Size latched at run start, never below the minimum
   always_ff @(posedge clk) begin
      if (state == st_idle && start) begin
         size <= (pkt_size < phy_test_cfg_pkg::min_pkt_size) ?
                 phy_test_cfg_pkg::pkt_size_width'(phy_test_cfg_pkg::min_pkt_size) :
                 pkt_size;
      end
   end

   phy_test_pktgen u_pktgen (
      .clk      (clk),
      .reset    (gen_reset),
      .rd_en    (gen_rd_en),
      .port     (port),
      .pattern  (curr_pat),
      .pkt_size (size),
      .seq_no   (seq_no + pkt_cnt),
      .data     (gen_data),
      .ctrl     (gen_ctrl),
      .done     (gen_done)
   );

endmodule

//--- verilog/phy_test_pktchk.sv
// PHY self-test packet checker
// Rebuilds each received packet from its own header and sequence word.
// Verdict comes one cycle after the word that carries the end marker.

`timescale 1ns/1ps

module phy_test_pktchk (
   input  logic                           clk,
   input  logic                           reset,
   input  phy_test_word_pkg::fifo_word_t  rx_data,
   input  logic                           rx_wr_en,
   output phy_test_word_pkg::chk_result_t result
);

   // Position in the received packet, 0 header, 1 sequence, 2 fill
   logic [1:0] rx_idx;
   logic rx_last;

   // Captured fields and the live view fed to the generator
   phy_test_word_pkg::pkt_hdr_t hdr_q;
   phy_test_word_pkg::pkt_hdr_t hdr_live;
   logic [phy_test_cfg_pkg::seq_no_width-1:0] seq_q;
   logic [phy_test_cfg_pkg::seq_no_width-1:0] seq_live;

   // Received word delayed to line up with the generator
   phy_test_word_pkg::fifo_word_t rx_q;
   phy_test_word_pkg::fifo_word_t expected;
   logic cmp_q;
   logic last_q;
   logic bad_q;
   logic word_bad;

   // Generator side
   logic gen_reset;
   logic gen_done;
   logic [31:0] gen_data;
   logic [3:0] gen_ctrl;

   assign rx_last = rx_wr_en && (phy_test_word_pkg::word_ctrl(rx_data) != 4'b0000);

   // Header and sequence are taken from the wire in their own cycle
   assign hdr_live = (rx_idx == 2'd0) ? phy_test_word_pkg::word_data(rx_data) : hdr_q;
   assign seq_live = (rx_idx == 2'd1) ? phy_test_word_pkg::word_data(rx_data) : seq_q;

   // ====================
   // Compare
   // Reserved header bits and all ctrl lanes are part of the match
   assign expected = phy_test_word_pkg::pack_word(gen_data, gen_ctrl);
   assign word_bad = cmp_q && (rx_q != expected);

   assign result.valid = last_q;
   assign result.good = !(bad_q || word_bad);
   assign result.pattern = hdr_q.pattern;

   // Realign the generator when the wire ends a packet before it does
   assign gen_reset = reset || (last_q && !gen_done);

   always_ff @(posedge clk) begin
      if (reset) begin
         rx_idx <= 2'd0;
         cmp_q <= 1'b0;
         last_q <= 1'b0;
         bad_q <= 1'b0;
      end else begin
         cmp_q <= rx_wr_en;
         last_q <= rx_last;

         // Sticky across the packet, cleared with its verdict
         if (last_q) begin
            bad_q <= 1'b0;
         end else if (word_bad) begin
            bad_q <= 1'b1;
         end

         if (rx_last) begin
            rx_idx <= 2'd0;
         end else if (rx_wr_en && rx_idx != 2'd2) begin
            rx_idx <= rx_idx + 1'b1;
         end
      end
   end

   // Payload capture
   always_ff @(posedge clk) begin
      rx_q <= rx_data;
      if (rx_wr_en && rx_idx == 2'd0) begin
         hdr_q <= hdr_live;
      end
      if (rx_wr_en && rx_idx == 2'd1) begin
         seq_q <= seq_live;
      end
   end

   // One strobe per received word
   phy_test_pktgen u_pktgen (
      .clk      (clk),
      .reset    (gen_reset),
      .rd_en    (rx_wr_en),
      .port     (hdr_live.port),
      .pattern  (hdr_live.pattern),
      .pkt_size (hdr_live.pkt_size),
      .seq_no   (seq_live),
      .data     (gen_data),
      .ctrl     (gen_ctrl),
      .done     (gen_done)
   );

endmodule

//--- verilog/phy_test_tally.sv
// PHY self-test tally
// Counts sent, good and bad packets per run and forms the pass level

`timescale 1ns/1ps

module phy_test_tally (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic                                     start,
   input  logic                                     busy,
   input  logic                                     pkt_done,
   input  phy_test_word_pkg::chk_result_t           result,
   output logic [phy_test_cfg_pkg::count_width-1:0] pkts_sent,
   output logic [phy_test_cfg_pkg::count_width-1:0] pkts_good,
   output logic [phy_test_cfg_pkg::count_width-1:0] pkts_bad,
   output logic                                     run_pass
);

   // ====================
   // Counters
   always_ff @(posedge clk) begin
      // New run clears the previous totals
      if (reset || (start && !busy)) begin
         pkts_sent <= '0;
         pkts_good <= '0;
         pkts_bad <= '0;
      end else begin
         if (pkt_done) begin
            pkts_sent <= pkts_sent + 1'b1;
         end
         if (result.valid && result.good) begin
            pkts_good <= pkts_good + 1'b1;
         end
         if (result.valid && !result.good) begin
            pkts_bad <= pkts_bad + 1'b1;
         end
      end
   end

   // Pass once the source is idle and every sent packet came back good.
   // A final pkt_done still in flight holds it off.
   assign run_pass = !busy && !pkt_done && (pkts_sent != '0) &&
                     (pkts_sent == pkts_good) && (pkts_bad == '0);

endmodule

//--- verilog/phy_test.sv
// PHY self-test top level
// Packet source and loopback checker side by side, results into the tally

`timescale 1ns/1ps

module phy_test (
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic                                        start,
   input  phy_test_cfg_pkg::pattern_t                  pat_en,
   input  logic [phy_test_cfg_pkg::pkt_size_width-1:0] pkt_size,
   input  logic [phy_test_cfg_pkg::port_width-1:0]     port,
   input  logic [phy_test_cfg_pkg::seq_no_width-1:0]   seq_no,
   input  logic                                        tx_almost_full,
   output phy_test_word_pkg::fifo_word_t               tx_data,
   output logic                                        tx_wr_en,
   input  phy_test_word_pkg::fifo_word_t               rx_data,
   input  logic                                        rx_wr_en,
   output logic                                        busy,
   output phy_test_cfg_pkg::pattern_t                  curr_pat,
   output logic                                        iter_done,
   output logic [phy_test_cfg_pkg::count_width-1:0]    pkts_sent,
   output logic [phy_test_cfg_pkg::count_width-1:0]    pkts_good,
   output logic [phy_test_cfg_pkg::count_width-1:0]    pkts_bad,
   output logic                                        run_pass
);

   logic pkt_done;
   phy_test_word_pkg::chk_result_t result;

   // TX side
   phy_test_pktsrc u_pktsrc (
      .clk            (clk),
      .reset          (reset),
      .start          (start),
      .pat_en         (pat_en),
      .pkt_size       (pkt_size),
      .port           (port),
      .seq_no         (seq_no),
      .tx_almost_full (tx_almost_full),
      .tx_data        (tx_data),
      .tx_wr_en       (tx_wr_en),
      .busy           (busy),
      .curr_pat       (curr_pat),
      .pkt_done       (pkt_done),
      .iter_done      (iter_done)
   );

   // RX side
   phy_test_pktchk u_pktchk (
      .clk      (clk),
      .reset    (reset),
      .rx_data  (rx_data),
      .rx_wr_en (rx_wr_en),
      .result   (result)
   );

   phy_test_tally u_tally (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .busy      (busy),
      .pkt_done  (pkt_done),
      .result    (result),
      .pkts_sent (pkts_sent),
      .pkts_good (pkts_good),
      .pkts_bad  (pkts_bad),
      .run_pass  (run_pass)
   );

endmodule

//--- verification/phy_test_tb.sv
// PHY self-test testbench
// TX is looped back to RX through one register stage, with optional bit error.
// A monitor checks every TX word against a reference packet model.

`timescale 1ns/1ps

module phy_test_tb;

   localparam int timeout_cycles = 20000;

   // DUT inputs
   logic clk;
   logic reset;
   logic start;
   phy_test_cfg_pkg::pattern_t pat_en;
   logic [phy_test_cfg_pkg::pkt_size_width-1:0] pkt_size;
   logic [phy_test_cfg_pkg::port_width-1:0] port;
   logic [phy_test_cfg_pkg::seq_no_width-1:0] seq_no;
   logic tx_almost_full = 1'b0;
   phy_test_word_pkg::fifo_word_t rx_data = '0;
   logic rx_wr_en = 1'b0;

   // DUT outputs
   phy_test_word_pkg::fifo_word_t tx_data;
   logic tx_wr_en;
   logic busy;
   phy_test_cfg_pkg::pattern_t curr_pat;
   logic iter_done;
   logic [phy_test_cfg_pkg::count_width-1:0] pkts_sent;
   logic [phy_test_cfg_pkg::count_width-1:0] pkts_good;
   logic [phy_test_cfg_pkg::count_width-1:0] pkts_bad;
   logic run_pass;

   // Stimulus controls
   integer seed = 32'he0a5;
   logic af_random = 1'b0;
   logic inject_error = 1'b0;
   int inject_word = 0;
   int rx_word_cnt = 0;

   // Monitor state, owned by the monitor process
   phy_test_cfg_pkg::pattern_t mon_pat = '0;
   phy_test_word_pkg::fifo_word_t exp_word;
   int mon_pkt = 0;
   int mon_widx = 0;
   int mon_words = 0;
   int mon_iters = 0;
   int mon_errors = 0;

   // Bookkeeping of the main sequence
   int errors = 0;
   int test_base = 0;
   int tests_run = 0;
   int tests_failed = 0;
   logic timed_out = 1'b0;

   phy_test UUT (
      .clk            (clk),
      .reset          (reset),
      .start          (start),
      .pat_en         (pat_en),
      .pkt_size       (pkt_size),
      .port           (port),
      .seq_no         (seq_no),
      .tx_almost_full (tx_almost_full),
      .tx_data        (tx_data),
      .tx_wr_en       (tx_wr_en),
      .rx_data        (rx_data),
      .rx_wr_en       (rx_wr_en),
      .busy           (busy),
      .curr_pat       (curr_pat),
      .iter_done      (iter_done),
      .pkts_sent      (pkts_sent),
      .pkts_good      (pkts_good),
      .pkts_bad       (pkts_bad),
      .run_pass       (run_pass)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ====================
   // Reference model

   // One Galois step, shift right and fold the taps in on a one out
   function automatic logic [31:0] lfsr_next(input logic [31:0] l);
      return {1'b0, l[31:1]} ^ (l[0] ? 32'h80200003 : 32'h0);
   endfunction

   // Ceiling of size/4
   function automatic int word_count(input logic [10:0] size);
      return (int'(size) + 3) / 4;
   endfunction

   // Lowest enabled pattern above cur, else the lowest enabled one
   function automatic phy_test_cfg_pkg::pattern_t next_enabled(
      input phy_test_cfg_pkg::pattern_t mask, input phy_test_cfg_pkg::pattern_t cur);
      int i;
      phy_test_cfg_pkg::pattern_t one;
      for (i = 0; i < phy_test_cfg_pkg::num_patterns; i++) begin
         one = '0;
         one[i] = 1'b1;
         if (mask[i] && one > cur) return one;
      end
      for (i = 0; i < phy_test_cfg_pkg::num_patterns; i++) begin
         one = '0;
         one[i] = 1'b1;
         if (mask[i]) return one;
      end
      return '0;
   endfunction

   function automatic phy_test_word_pkg::fifo_word_t expected_word(
      input logic [2:0] hdr_port, input phy_test_cfg_pkg::pattern_t pat,
      input logic [10:0] size, input logic [31:0] seq, input int idx);
      logic [31:0] d;
      logic [31:0] l;
      logic [3:0] c;
      int n;
      int k;
      phy_test_word_pkg::fifo_word_t w;
      if (idx == 0) begin
         d = {hdr_port, pat, 13'd0, size};
      end else if (idx == 1) begin
         d = seq;
      end else begin
         case (pat)
            5'b00001: d = 32'h00000000;
            5'b00010: d = 32'hffffffff;
            5'b00100: d = 32'h55555555;
            5'b01000: d = 32'haaaaaaaa;
            default: begin
               // Seeded with the sequence number, one step per fill word
               l = seq;
               for (k = 1; k < idx; k++) l = lfsr_next(l);
               d = l;
            end
         endcase
      end
      c = 4'b0000;
      if (idx == word_count(size) - 1) begin
         n = int'(size) % 4;
         if (n == 0) n = 4;
         // Lane 3 holds byte 0
         c = 4'b0001 << (4 - n);
      end
      for (k = 0; k < 4; k++) begin
         w.lane[k].ctrl = c[k];
         w.lane[k].data = d[8*k +: 8];
      end
      return w;
   endfunction

   // ====================
   // Back-pressure and loopback
   always @(posedge clk) begin
      if (af_random) tx_almost_full <= (($random(seed) & 3) == 0);
      else tx_almost_full <= 1'b0;
   end

   always @(posedge clk) begin
      rx_wr_en <= tx_wr_en;
      if (!busy) begin
         rx_word_cnt <= 0;
      end else if (tx_wr_en) begin
         // Flip data bit 0 of the chosen word of the run
         if (inject_error && rx_word_cnt == inject_word) rx_data <= tx_data ^ 36'h1;
         else rx_data <= tx_data;
         rx_word_cnt <= rx_word_cnt + 1;
      end
   end

   // ====================
   // TX monitor, sampled mid-cycle
   always @(negedge clk) begin
      if (!reset) begin
         // New run, same condition that clears the tally
         if (start && !busy) begin
            mon_pat = next_enabled(pat_en, '0);
            mon_pkt = 0;
            mon_widx = 0;
            mon_words = 0;
            mon_iters = 0;
         end
         if (tx_wr_en) begin
            if (tx_almost_full) begin
               $display("ERROR: write to the TX FIFO while tx_almost_full is high");
               mon_errors++;
            end
            // Pattern in use for the packet being written
            if (curr_pat !== mon_pat) begin
               $display("MISMATCH curr_pat pkt %0d: got 0x%h expected 0x%h",
                        mon_pkt, curr_pat, mon_pat);
               mon_errors++;
            end
            exp_word = expected_word(port, mon_pat, pkt_size, seq_no + 32'(mon_pkt), mon_widx);
            if (tx_data !== exp_word) begin
               $display("MISMATCH tx_data pkt %0d word %0d: got 0x%h expected 0x%h",
                        mon_pkt, mon_widx, tx_data, exp_word);
               mon_errors++;
            end
            mon_words++;
            if (mon_widx == word_count(pkt_size) - 1) begin
               mon_widx = 0;
               mon_pkt++;
               mon_pat = next_enabled(pat_en, mon_pat);
            end else begin
               mon_widx++;
            end
         end
         if (iter_done) mon_iters++;
      end
   end

   // ====================
   // Helpers
   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
   endtask

   // Later waits fall through once one has expired
   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      timed_out = 1'b1;
      errors++;
   endtask

   task automatic wait_for_busy(input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while (!timed_out && busy !== level) begin
         if (n == timeout_cycles) begin
            report_timeout(level ? "busy never rose" : "busy never fell");
         end else begin
            n++;
            @(negedge clk);
         end
      end
   endtask

   // Verdicts trail the last write by the loopback, checker and tally stages
   task automatic wait_for_results();
      int n;
      n = 0;
      while (!timed_out && (int'(pkts_sent) != mon_pkt ||
                            int'(pkts_good) + int'(pkts_bad) != mon_pkt)) begin
         if (n == timeout_cycles) begin
            report_timeout("tally counters never caught up with the packets sent");
         end else begin
            n++;
            @(negedge clk);
         end
      end
   endtask

   task automatic wait_for_iter(input int count);
      int n;
      n = 0;
      while (!timed_out && mon_iters < count) begin
         if (n == timeout_cycles) begin
            report_timeout("iter_done never pulsed");
         end else begin
            n++;
            @(negedge clk);
         end
      end
   endtask

   // One pass with a single start pulse
   task automatic run_once(input phy_test_cfg_pkg::pattern_t pat, input logic [10:0] size,
                           input logic af);
      @(posedge clk);
      pat_en <= pat;
      pkt_size <= size;
      af_random <= af;
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      wait_for_busy(1'b1);
      wait_for_busy(1'b0);
      wait_for_results();
   endtask

   task automatic finish_test(input string name);
      int n;
      n = errors + mon_errors - test_base;
      tests_run++;
      if (n != 0) tests_failed++;
      $display("test %0d %s: %s with %0d errors", tests_run, name, (n == 0) ? "ok" : "failed", n);
      test_base = errors + mon_errors;
   endtask

   // ====================
   // Main sequence
   initial begin
      reset = 1'b1;
      start = 1'b0;
      pat_en = '0;
      pkt_size = 11'd64;
      port = 3'd5;
      seq_no = 32'h10000000;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      // Reset defaults
      @(negedge clk);
      if (busy !== 1'b0) report_mismatch("busy", busy, 0);
      if (tx_wr_en !== 1'b0) report_mismatch("tx_wr_en", tx_wr_en, 0);
      if (iter_done !== 1'b0) report_mismatch("iter_done", iter_done, 0);
      if (pkts_sent !== '0) report_mismatch("pkts_sent", pkts_sent, 0);
      if (pkts_good !== '0) report_mismatch("pkts_good", pkts_good, 0);
      if (pkts_bad !== '0) report_mismatch("pkts_bad", pkts_bad, 0);
      finish_test("reset defaults");

      // Single pattern, no back-pressure
      run_once(5'b00100, 11'd64, 1'b0);
      if (pkts_sent !== 16'd1) report_mismatch("pkts_sent", pkts_sent, 1);
      if (pkts_good !== 16'd1) report_mismatch("pkts_good", pkts_good, 1);
      if (mon_iters != 1) report_mismatch("iter_done pulses", mon_iters, 1);
      if (run_pass !== 1'b1) report_mismatch("run_pass", run_pass, 1);
      finish_test("single pattern");

      // All patterns, sequence number wrapping, random almost-full
      @(posedge clk);
      seq_no <= 32'hfffffffe;
      run_once(5'b11111, 11'd37, 1'b1);
      if (pkts_sent !== 16'd5) report_mismatch("pkts_sent", pkts_sent, 5);
      if (pkts_good !== 16'd5) report_mismatch("pkts_good", pkts_good, 5);
      if (pkts_bad !== 16'd0) report_mismatch("pkts_bad", pkts_bad, 0);
      if (mon_iters != 1) report_mismatch("iter_done pulses", mon_iters, 1);
      if (run_pass !== 1'b1) report_mismatch("run_pass", run_pass, 1);
      finish_test("all patterns with back-pressure");

      // Every end marker position
      for (int s = 8; s <= 12; s++) begin
         run_once(5'b10000, 11'(s), 1'b0);
         if (mon_words != (s + 3) / 4) report_mismatch("word count", mon_words, (s + 3) / 4);
         if (pkts_good !== 16'd1) report_mismatch("pkts_good", pkts_good, 1);
      end
      finish_test("sizes 8 to 12");

      // Corrupted fill word in the first packet
      inject_word <= 3;
      inject_error <= 1'b1;
      run_once(5'b00011, 11'd20, 1'b0);
      inject_error <= 1'b0;
      if (pkts_sent !== 16'd2) report_mismatch("pkts_sent", pkts_sent, 2);
      if (pkts_bad !== 16'd1) report_mismatch("pkts_bad", pkts_bad, 1);
      if (pkts_good !== 16'd1) report_mismatch("pkts_good", pkts_good, 1);
      if (run_pass !== 1'b0) report_mismatch("run_pass", run_pass, 0);
      finish_test("loopback bit error");

      // Start held over the first wrap gives a second pass
      @(posedge clk);
      pat_en <= 5'b10101;
      pkt_size <= 11'd16;
      start <= 1'b1;
      wait_for_busy(1'b1);
      wait_for_iter(1);
      @(posedge clk);
      start <= 1'b0;
      wait_for_busy(1'b0);
      wait_for_results();
      if (mon_iters != 2) report_mismatch("iter_done pulses", mon_iters, 2);
      if (pkts_sent !== 16'd6) report_mismatch("pkts_sent", pkts_sent, 6);
      if (pkts_good !== 16'd6) report_mismatch("pkts_good", pkts_good, 6);
      // Nothing enabled, nothing starts
      @(posedge clk);
      pat_en <= '0;
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      repeat (20) begin
         @(negedge clk);
         if (busy !== 1'b0) begin
            $display("ERROR: busy rose with no pattern enabled");
            errors++;
         end
      end
      finish_test("two passes and empty enable");

      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, errors + mon_errors);
      if (errors + mon_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- phy_test.f
verilog/phy_test_cfg_pkg.sv
verilog/phy_test_word_pkg.sv
verilog/phy_test_pktgen.sv
verilog/phy_test_pktsrc.sv
verilog/phy_test_pktchk.sv
verilog/phy_test_tally.sv
verilog/phy_test.sv
verification/phy_test_tb.sv

//--- build.sh
#!/bin/sh
# Compile the PHY self-test testbench with Verilator, run it, then judge the log

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module phy_test_tb \
   -f phy_test.f -o phy_test_sim \
   && ./obj_dir/phy_test_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log

grep -qx "No errors" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
